/* Makefile */
SRCS := $(shell cat filelist.f)

.PHONY: run clean

obj_dir/Vrv_core_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f --top-module rv_core_tb

run: obj_dir/Vrv_core_tb
	@out=$$(./obj_dir/Vrv_core_tb 2>&1); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* filelist.f */
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/ctrl_if.sv
source/controller.sv
source/alu.sv
source/reg_file.sv
source/datapath.sv
source/rv_core_top.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

/* source/alu.sv */
module alu (
    input  logic [rv_isa_pkg::xlen-1:0] a,
    input  logic [rv_isa_pkg::xlen-1:0] b,
    input  core_ctrl_pkg::alu_ctrl_t    op,
    output logic [rv_isa_pkg::xlen-1:0] y,
    output logic                        zero
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];  // low five bits only
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            core_ctrl_pkg::ac_add:  y = a + b;
            core_ctrl_pkg::ac_sub:  y = a - b;
            core_ctrl_pkg::ac_and:  y = a & b;
            core_ctrl_pkg::ac_or:   y = a | b;
            core_ctrl_pkg::ac_xor:  y = a ^ b;
            core_ctrl_pkg::ac_slt: begin
                y = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_signed};
            end
            core_ctrl_pkg::ac_sltu: begin
                y = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            core_ctrl_pkg::ac_sll:  y = a << shamt;
            core_ctrl_pkg::ac_srl:  y = a >> shamt;
            core_ctrl_pkg::ac_sra:  y = $unsigned($signed(a) >>> shamt);
            default:                y = '0;
        endcase
    end

    // beq/bne look at this after the xor
    assign zero = (y == '0);

endmodule

/* source/controller.sv */
module controller (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    ctrl_if.decoder    ctrl
);
    typedef enum logic [1:0] {cls_none, cls_branch, cls_jal, cls_jalr} ctrl_class_t;

    core_ctrl_pkg::alu_op_t alu_op;
    ctrl_class_t            ctrl_class;
    logic                   is_rtype;

    assign is_rtype = (opcode == rv_isa_pkg::op_reg);

    // main decoder
    always_comb begin
        ctrl.alu_src    = 1'b0;
        ctrl.memwrite   = 1'b0;
        ctrl.memread    = 1'b0;
        ctrl.regwrite   = 1'b0;
        ctrl.imm_sel    = core_ctrl_pkg::imm_i;
        ctrl.result_src = core_ctrl_pkg::res_alu;
        alu_op          = core_ctrl_pkg::alu_add;
        ctrl_class      = cls_none;

        case (opcode)
            rv_isa_pkg::op_load: begin
                if (funct3 == rv_isa_pkg::f3_lw_sw) begin  // word only
                    ctrl.memread    = 1'b1;
                    ctrl.regwrite   = 1'b1;
                    ctrl.alu_src    = 1'b1;
                    ctrl.result_src = core_ctrl_pkg::res_mem;
                end
            end
            rv_isa_pkg::op_store: begin
                if (funct3 == rv_isa_pkg::f3_lw_sw) begin
                    ctrl.memwrite = 1'b1;
                    ctrl.alu_src  = 1'b1;
                    ctrl.imm_sel  = core_ctrl_pkg::imm_s;
                end
            end
            rv_isa_pkg::op_reg: begin
                ctrl.regwrite = 1'b1;
                alu_op        = core_ctrl_pkg::alu_func;
            end
            rv_isa_pkg::op_imm: begin
                ctrl.regwrite = 1'b1;
                ctrl.alu_src  = 1'b1;
                alu_op        = core_ctrl_pkg::alu_func;
            end
            rv_isa_pkg::op_branch: begin
                ctrl.imm_sel = core_ctrl_pkg::imm_b;
                alu_op       = core_ctrl_pkg::alu_cmp;
                ctrl_class   = cls_branch;
            end
            rv_isa_pkg::op_jal: begin
                ctrl.regwrite   = 1'b1;
                ctrl.imm_sel    = core_ctrl_pkg::imm_j;
                ctrl.result_src = core_ctrl_pkg::res_link;
                ctrl_class      = cls_jal;
            end
            rv_isa_pkg::op_jalr: begin
                ctrl.regwrite   = 1'b1;
                ctrl.alu_src    = 1'b1;  // rs1 + imm as target
                ctrl.result_src = core_ctrl_pkg::res_link;
                ctrl_class      = cls_jalr;
            end
            default: ;  // unsupported, falls through as no-op
        endcase
    end

    // alu decoder
    always_comb begin
        ctrl.alu_control = core_ctrl_pkg::ac_add;
        case (alu_op)
            core_ctrl_pkg::alu_cmp: ctrl.alu_control = core_ctrl_pkg::ac_xor;  // zero on equal
            core_ctrl_pkg::alu_func: begin
                case (funct3)
                    rv_isa_pkg::f3_add_sub: begin
                        if (is_rtype && funct7 == rv_isa_pkg::f7_alt)
                            ctrl.alu_control = core_ctrl_pkg::ac_sub;
                    end
                    rv_isa_pkg::f3_sll:  ctrl.alu_control = core_ctrl_pkg::ac_sll;
                    rv_isa_pkg::f3_slt:  ctrl.alu_control = core_ctrl_pkg::ac_slt;
                    rv_isa_pkg::f3_sltu: ctrl.alu_control = core_ctrl_pkg::ac_sltu;
                    rv_isa_pkg::f3_xor:  ctrl.alu_control = core_ctrl_pkg::ac_xor;
                    rv_isa_pkg::f3_srl_sra: begin
                        ctrl.alu_control = funct7[5] ? core_ctrl_pkg::ac_sra
                                                     : core_ctrl_pkg::ac_srl;
                    end
                    rv_isa_pkg::f3_or:   ctrl.alu_control = core_ctrl_pkg::ac_or;
                    rv_isa_pkg::f3_and:  ctrl.alu_control = core_ctrl_pkg::ac_and;
                    default: ;
                endcase
            end
            default: ;  // alu_add
        endcase
    end

    // branch decoder
    always_comb begin
        ctrl.pc_src = core_ctrl_pkg::pc_plus4;
        case (ctrl_class)
            cls_branch: begin
                if (funct3 == rv_isa_pkg::f3_beq && ctrl.alu_zero)
                    ctrl.pc_src = core_ctrl_pkg::pc_branch;
                else if (funct3 == rv_isa_pkg::f3_bne && !ctrl.alu_zero)
                    ctrl.pc_src = core_ctrl_pkg::pc_branch;
            end
            cls_jal:  ctrl.pc_src = core_ctrl_pkg::pc_branch;  // pc + imm_j
            cls_jalr: ctrl.pc_src = core_ctrl_pkg::pc_reg;
            default: ;
        endcase
    end

endmodule

/* source/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // alu operation, codes follow the decoder table
    typedef enum logic [3:0] {
        ac_add  = 4'd0,
        ac_sub  = 4'd1,
        ac_and  = 4'd2,
        ac_or   = 4'd3,
        ac_slt  = 4'd4,
        ac_xor  = 4'd5,
        ac_sltu = 4'd6,
        ac_sll  = 4'd7,
        ac_srl  = 4'd8,
        ac_sra  = 4'd9
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        pc_plus4  = 2'd0,
        pc_branch = 2'd1,  // pc + imm
        pc_reg    = 2'd2   // alu result, bit 0 cleared
    } pc_src_t;

    typedef enum logic [1:0] {imm_i, imm_s, imm_b, imm_j} imm_sel_t;

    typedef enum logic [1:0] {
        res_alu  = 2'd0,
        res_mem  = 2'd1,
        res_link = 2'd2   // pc + 4
    } result_src_t;

    // class of alu work handed from main decoder to alu decoder
    typedef enum logic [1:0] {alu_add, alu_sub, alu_func, alu_cmp} alu_op_t;

endpackage

/* source/ctrl_if.sv */
interface ctrl_if;

    logic                      alu_src;     // 1 selects immediate
    logic                      memwrite;
    logic                      memread;
    logic                      regwrite;
    core_ctrl_pkg::alu_ctrl_t   alu_control;
    core_ctrl_pkg::pc_src_t     pc_src;
    core_ctrl_pkg::imm_sel_t    imm_sel;
    core_ctrl_pkg::result_src_t result_src;
    logic                      alu_zero;    // status back to decoder

    modport decoder (
        output alu_src, memwrite, memread, regwrite,
        output alu_control, pc_src, imm_sel, result_src,
        input  alu_zero
    );

    modport datapath (
        input  alu_src, memwrite, memread, regwrite,
        input  alu_control, pc_src, imm_sel, result_src,
        output alu_zero
    );

endinterface

/* source/datapath.sv */
module datapath (
    input  logic                              clk,
    input  logic                              arst_n,
    ctrl_if.datapath                          ctrl,
    output logic [rv_isa_pkg::xlen-1:0]       imem_addr,
    input  logic [rv_isa_pkg::xlen-1:0]       imem_instr,
    output logic                              dmem_valid,
    output logic                              dmem_write,
    output logic [rv_isa_pkg::xlen-1:0]       dmem_addr,
    output logic [rv_isa_pkg::xlen-1:0]       dmem_wdata,
    input  logic                              dmem_ready,
    input  logic [rv_isa_pkg::xlen-1:0]       dmem_rdata,
    output logic                              retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc,
    output logic                              retire_we,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_isa_pkg::xlen-1:0]       retire_wdata
);
    logic [rv_isa_pkg::xlen-1:0]       pc;
    logic [rv_isa_pkg::xlen-1:0]       pc_plus4;
    logic [rv_isa_pkg::xlen-1:0]       pc_next;
    logic                              started;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
    logic [rv_isa_pkg::reg_addr_w-1:0] rd;
    logic [rv_isa_pkg::xlen-1:0]       imm;
    logic [rv_isa_pkg::xlen-1:0]       rdata1;
    logic [rv_isa_pkg::xlen-1:0]       rdata2;
    logic [rv_isa_pkg::xlen-1:0]       alu_b;
    logic [rv_isa_pkg::xlen-1:0]       alu_y;
    logic [rv_isa_pkg::xlen-1:0]       wb_data;
    logic                              mem_access;
    logic                              stall;
    logic                              advance;
    logic                              rf_we;

    assign imem_addr = pc;
    assign rs1       = imem_instr[19:15];
    assign rs2       = imem_instr[24:20];
    assign rd        = imem_instr[11:7];

    // immediate generation
    always_comb begin
        case (ctrl.imm_sel)
            core_ctrl_pkg::imm_s: begin
                imm = {{20{imem_instr[31]}}, imem_instr[31:25], imem_instr[11:7]};
            end
            core_ctrl_pkg::imm_b: begin
                imm = {{19{imem_instr[31]}}, imem_instr[31], imem_instr[7],
                       imem_instr[30:25], imem_instr[11:8], 1'b0};
            end
            core_ctrl_pkg::imm_j: begin
                imm = {{11{imem_instr[31]}}, imem_instr[31], imem_instr[19:12],
                       imem_instr[20], imem_instr[30:21], 1'b0};
            end
            default: imm = {{20{imem_instr[31]}}, imem_instr[31:20]};  // imm_i
        endcase
    end

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (rf_we),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_b = ctrl.alu_src ? imm : rdata2;

    alu u_alu (
        .a    (rdata1),
        .b    (alu_b),
        .op   (ctrl.alu_control),
        .y    (alu_y),
        .zero (ctrl.alu_zero)
    );

    // data port, held by the stalled pc
    assign mem_access = started && (ctrl.memread || ctrl.memwrite);
    assign dmem_valid = mem_access;
    assign dmem_write = ctrl.memwrite;
    assign dmem_addr  = alu_y;
    assign dmem_wdata = rdata2;

    assign stall   = mem_access && !dmem_ready;
    assign advance = started && !stall;  // instruction commits this cycle

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.result_src)
            core_ctrl_pkg::res_mem:  wb_data = dmem_rdata;
            core_ctrl_pkg::res_link: wb_data = pc_plus4;
            default:                 wb_data = alu_y;
        endcase
    end

    always_comb begin
        case (ctrl.pc_src)
            core_ctrl_pkg::pc_branch: pc_next = pc + imm;
            core_ctrl_pkg::pc_reg:    pc_next = {alu_y[rv_isa_pkg::xlen-1:1], 1'b0};
            default:                  pc_next = pc_plus4;
        endcase
    end

    assign rf_we = ctrl.regwrite && advance;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= '0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;  // first fetch one edge after reset
            if (advance) begin
                pc <= pc_next;
            end
        end
    end

    // retire report mirrors the committed write
    assign retire_valid = advance;
    assign retire_pc    = pc;
    assign retire_we    = rf_we;
    assign retire_rd    = rd;
    assign retire_wdata = wb_data;

endmodule

/* source/reg_file.sv */
module reg_file (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              we,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_isa_pkg::xlen-1:0]       wdata,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_isa_pkg::xlen-1:0]       rdata1,
    output logic [rv_isa_pkg::xlen-1:0]       rdata2
);
    logic [rv_isa_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* source/rv_core_top.sv */
module rv_core_top (
    input  logic                              clk,
    input  logic                              arst_n,
    output logic [rv_isa_pkg::xlen-1:0]       imem_addr,
    input  logic [rv_isa_pkg::xlen-1:0]       imem_instr,
    output logic                              dmem_valid,
    output logic                              dmem_write,
    output logic [rv_isa_pkg::xlen-1:0]       dmem_addr,
    output logic [rv_isa_pkg::xlen-1:0]       dmem_wdata,
    input  logic                              dmem_ready,
    input  logic [rv_isa_pkg::xlen-1:0]       dmem_rdata,
    output logic                              retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc,
    output logic                              retire_we,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_isa_pkg::xlen-1:0]       retire_wdata
);
    ctrl_if ctrl_bus ();

    // decode fields straight from the fetched word
    controller u_controller (
        .opcode (imem_instr[6:0]),
        .funct3 (imem_instr[14:12]),
        .funct7 (imem_instr[31:25]),
        .ctrl   (ctrl_bus.decoder)
    );

    datapath u_datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctrl         (ctrl_bus.datapath),
        .imem_addr    (imem_addr),
        .imem_instr   (imem_instr),
        .dmem_valid   (dmem_valid),
        .dmem_write   (dmem_write),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_ready   (dmem_ready),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata)
    );

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    // architectural widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_load   = 7'b0000011;  // lw
    localparam logic [6:0] op_store  = 7'b0100011;  // sw
    localparam logic [6:0] op_reg    = 7'b0110011;  // r-type arithmetic
    localparam logic [6:0] op_imm    = 7'b0010011;  // i-type arithmetic
    localparam logic [6:0] op_branch = 7'b1100011;  // beq, bne
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // funct3 for the arithmetic group, instr[14:12]
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // word width for loads and stores
    localparam logic [2:0] f3_lw_sw = 3'b010;

    // funct7 selecting sub and sra, instr[31:25]
    localparam logic [6:0] f7_alt = 7'b0100000;

endpackage

/* tb/rv_core_sva.sv */
module rv_core_sva (
    input logic        clk,
    input logic        arst_n,
    input logic        dmem_valid,
    input logic        dmem_ready,
    input logic        dmem_write,
    input logic [31:0] dmem_addr,
    input logic [31:0] dmem_wdata,
    input logic        retire_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // request must hold still until accepted
    property p_stall_stable;
        @(posedge clk) disable iff (!arst_n)
        dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr)
            && $stable(dmem_wdata) && $stable(dmem_write);
    endproperty

    property p_quiet_in_reset;
        @(posedge clk) !arst_n |-> !dmem_valid && !retire_valid;
    endproperty

    property p_no_retire_in_stall;
        @(posedge clk) disable iff (!arst_n)
        dmem_valid && !dmem_ready |-> !retire_valid;
    endproperty

    a_stall_stable: assert property (p_stall_stable)
        else $error("data request changed during a stall");
    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else $error("memory request or retire during reset");
    a_no_retire_in_stall: assert property (p_no_retire_in_stall)
        else $error("retire reported while the data port stalls");

endmodule

/* tb/rv_core_tb.sv */
module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_programs  = 20;
    localparam int halt_idx    = 64;  // word index of jal x0,0
    localparam int cycle_limit = n_programs * (10 + 64 * 4 + 10);

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_instr;
    logic        dmem_valid;
    logic        dmem_write;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_ready = 1'b0;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;

    logic [31:0] prog [128];
    logic [31:0] dmem [64];
    logic [31:0] mmem [64];  // reference model state
    logic [31:0] mregs [32];
    logic [31:0] mpc;
    logic        done;
    int          prog_no;
    int          cycles = 0;
    int          low_run;

    rv_core_top UUT (.*);

    bind rv_core_top rv_core_sva u_sva (.*);

    always #5 clk = ~clk;

    assign imem_instr = prog[imem_addr[8:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s (program %0d, pc %h): expected %h, actual %h",
                     name, prog_no, mpc, exp, act);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        return (32'h9e3779b9 * (32'(idx) + 32'd1)) ^ 32'(prog_no << 8);
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic gen_program();
        int          kind [64];
        bit          jr_slot [65];
        int          i;
        int          t;
        logic [31:0] r;
        logic [4:0]  jr_reg;
        logic [2:0]  f3;
        logic        alt;
        for (i = 0; i < 128; i++) begin
            prog[i] = 32'h0000006f;  // halt everywhere past the program
            if (i <= halt_idx)
                jr_slot[i] = 1'b0;
        end
        // first pass places addi/jalr pairs so targets can avoid them
        i = 0;
        while (i < 64) begin
            kind[i] = int'($urandom % 10);
            if (kind[i] == 8 && i <= 62) begin
                kind[i + 1] = 10;
                jr_slot[i + 1] = 1'b1;
                i += 2;
            end else begin
                if (kind[i] == 8)
                    kind[i] = 2;
                i++;
            end
        end
        for (i = 0; i < 64; i++) begin
            r  = $urandom;
            f3 = r[2:0];
            t  = i + 1 + int'($urandom % 32'(halt_idx - i));  // forward, up to halt
            if (jr_slot[t])
                t++;
            case (kind[i])
                0, 1: begin
                    alt = r[3] && (f3 == 3'd0 || f3 == 3'd5);
                    prog[i] = {alt ? 7'h20 : 7'h00, r[8:4], r[13:9], f3, r[18:14], 7'h33};
                end
                2, 3: begin
                    if (f3 == 3'd1 || f3 == 3'd5)
                        prog[i] = enc_i({r[3] ? 7'h20 : 7'h00, r[8:4]}, r[13:9], f3,
                                        r[18:14], 7'h13);
                    else
                        prog[i] = enc_i(r[31:20], r[13:9], f3, r[18:14], 7'h13);
                end
                4: prog[i] = enc_i(12'({r[5:0], 2'b00}), 5'd0, 3'd2, r[18:14], 7'h03);
                5: prog[i] = {4'b0, r[5:3], r[13:9], 5'd0, 3'd2, r[2:0], 2'b00, 7'h23};
                6: prog[i] = enc_b(13'((t - i) * 4), r[8:4], r[13:9], {2'b00, r[3]});
                7: prog[i] = enc_j(21'((t - i) * 4), r[18:14]);
                8: begin
                    t = i + 2 + int'($urandom % 32'(halt_idx - i - 1));
                    if (jr_slot[t])
                        t++;
                    jr_reg = {r[7:4], 1'b1};  // never x0
                    prog[i] = enc_i(12'(t * 4), 5'd0, 3'd0, jr_reg, 7'h13);
                    prog[i + 1] = enc_i({11'b0, r[3]}, jr_reg, 3'd0, r[18:14], 7'h67);
                end
                9: begin
                    if (r[3])
                        prog[i] = enc_b(13'((t - i) * 4), r[8:4], r[13:9], 3'b100);  // blt
                    else
                        prog[i] = {r[31:7], 7'h0b};  // custom opcode
                end
                default: ;  // jalr already placed
            endcase
        end
    endtask

    task automatic model_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [31:0] npc;
        logic [31:0] wdata;
        logic [31:0] addr;
        logic        we;
        logic        mem;
        ins   = prog[mpc[8:2]];
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        immi  = {{20{ins[31]}}, ins[31:20]};
        npc   = mpc + 32'd4;
        wdata = 32'd0;
        we    = 1'b0;
        mem   = 1'b0;
        check("retire_pc", mpc, retire_pc);
        check("imem_addr", mpc, imem_addr);
        case (ins[6:0])
            7'h33: begin
                we    = 1'b1;
                wdata = ref_alu(ins[14:12], ins[30], a, b);
            end
            7'h13: begin
                we    = 1'b1;
                wdata = ref_alu(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immi);
            end
            7'h03: if (ins[14:12] == 3'd2) begin
                addr  = a + immi;
                mem   = 1'b1;
                check("load addr", addr, dmem_addr);
                check("load write", 32'd0, 32'(dmem_write));
                we    = 1'b1;
                wdata = mmem[addr[7:2]];
            end
            7'h23: if (ins[14:12] == 3'd2) begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem  = 1'b1;
                check("store addr", addr, dmem_addr);
                check("store data", b, dmem_wdata);
                check("store write", 32'd1, 32'(dmem_write));
                mmem[addr[7:2]] = b;
            end
            7'h63: begin
                if ((ins[14:12] == 3'd0 && a == b) || (ins[14:12] == 3'd1 && a != b))
                    npc = mpc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h6f: begin
                we    = 1'b1;
                wdata = mpc + 32'd4;
                npc   = mpc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                we    = 1'b1;
                wdata = mpc + 32'd4;
                npc   = (a + immi) & ~32'd1;
            end
            default: ;  // unsupported word, plain pc+4
        endcase
        check("dmem_valid", 32'(mem), 32'(dmem_valid));
        check("retire_we", 32'(we), 32'(retire_we));
        if (we) begin
            check("retire_rd", 32'(ins[11:7]), 32'(retire_rd));
            check("retire_wdata", wdata, retire_wdata);
            if (ins[11:7] != 5'd0)
                mregs[ins[11:7]] = wdata;
        end
        mpc = npc;
    endtask

    // memory model, ready generator and checker
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fill_word(i);
                mmem[i] = fill_word(i);
            end
            for (int i = 0; i < 32; i++)
                mregs[i] = 32'd0;
            mpc  = 32'd0;
            done <= 1'b0;
            low_run = 0;
            dmem_ready <= 1'b0;
        end else begin
            if (dmem_valid && dmem_ready && dmem_write)
                dmem[dmem_addr[7:2]] <= dmem_wdata;
            if (retire_valid && !done) begin
                if (retire_pc == 32'(halt_idx * 4))
                    done <= 1'b1;
                model_step();
            end
            // never more than three low cycles in a row
            if (low_run >= 3 || $urandom % 2 == 0) begin
                dmem_ready <= 1'b1;
                low_run = 0;
            end else begin
                dmem_ready <= 1'b0;
                low_run++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: programs did not reach the halt within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        arst_n <= 1'b0;  // core in reset from time zero
        void'($urandom(32'h641c));
        for (int p = 0; p < n_programs; p++) begin
            @(posedge clk);
            arst_n <= 1'b0;
            prog_no = p;
            gen_program();
            repeat (10) @(posedge clk);
            arst_n <= 1'b1;
            do @(posedge clk); while (!done);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
